//--- Bender.yml
package:
  name: soc_peripherals

sources:
  - soc_periph_pkg.sv
  - apb_if.sv
  - periph_bus_decoder.sv
  - apb_gpio.sv
  - apb_timer_unit.sv
  - soc_event_map.sv
  - soc_peripherals.sv
  - target: test
    files:
      - tb_soc_peripherals_assert.sv
      - tb_soc_peripherals.sv

//--- apb_gpio.sv
// APB GPIO block with direction and output registers, input sync and edge interrupts
`timescale 1ns/1ps

module apb_gpio (
    input  logic                             clk_i,
    input  logic                             rst_n_i,
    apb_if.slave                             apb,
    input  logic [soc_periph_pkg::NGPIO-1:0] gpio_in_i,
    output logic [soc_periph_pkg::NGPIO-1:0] gpio_out_o,
    output logic [soc_periph_pkg::NGPIO-1:0] gpio_dir_o,
    output logic                             gpio_event_o
);

    soc_periph_pkg::gpio_reg_e          reg_addr;
    logic                               wr_en;
    logic                               rd_en;
    logic [soc_periph_pkg::NGPIO-1:0]   sync_q1;
    logic [soc_periph_pkg::NGPIO-1:0]   sync_q2;
    logic [soc_periph_pkg::NGPIO-1:0]   hist_q;
    logic [soc_periph_pkg::NGPIO-1:0]   rise;
    logic [soc_periph_pkg::NGPIO-1:0]   dir_q;
    logic [soc_periph_pkg::NGPIO-1:0]   out_q;
    logic [soc_periph_pkg::NGPIO-1:0]   inten_q;
    logic [soc_periph_pkg::NGPIO-1:0]   status_q;
    logic                               status_clr;

    // Access completes in the access phase, pready is always high
    assign reg_addr   = soc_periph_pkg::gpio_reg_e'(apb.paddr);
    assign wr_en      = apb.psel & apb.penable & apb.pwrite;
    assign rd_en      = apb.psel & apb.penable & ~apb.pwrite;
    assign status_clr = rd_en & (reg_addr == soc_periph_pkg::GPIO_INTSTATUS);

    //////////////////////////////////////////////////////////////////////
    // Input synchronizer and rising edge detect
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sync_q1 <= '0;
            sync_q2 <= '0;
            hist_q  <= '0;
        end else begin
            sync_q1 <= gpio_in_i;
            sync_q2 <= sync_q1;
            hist_q  <= sync_q2;
        end
    end

    assign rise         = sync_q2 & ~hist_q;
    // One pulse per cycle with any enabled rising pin
    assign gpio_event_o = |(rise & inten_q);

    //////////////////////////////////////////////////////////////////////
    // Register file
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            dir_q    <= '0;
            out_q    <= '0;
            inten_q  <= '0;
            status_q <= '0;
        end else begin
            if (wr_en) begin
                case (reg_addr)
                    soc_periph_pkg::GPIO_PADDIR: dir_q   <= apb.pwdata;
                    soc_periph_pkg::GPIO_PADOUT: out_q   <= apb.pwdata;
                    soc_periph_pkg::GPIO_INTEN:  inten_q <= apb.pwdata;
                    default: ;
                endcase
            end
            // New edges win over the read clear
            status_q <= (status_q & {soc_periph_pkg::NGPIO{~status_clr}}) | (rise & inten_q);
        end
    end

    // Read mux, unknown offsets give zero
    always_comb begin
        case (reg_addr)
            soc_periph_pkg::GPIO_PADDIR:    apb.prdata = dir_q;
            soc_periph_pkg::GPIO_PADIN:     apb.prdata = sync_q2;
            soc_periph_pkg::GPIO_PADOUT:    apb.prdata = out_q;
            soc_periph_pkg::GPIO_INTEN:     apb.prdata = inten_q;
            soc_periph_pkg::GPIO_INTSTATUS: apb.prdata = status_q;
            default:                        apb.prdata = '0;
        endcase
    end

    assign apb.pready  = 1'b1;
    assign apb.pslverr = 1'b0;
    assign gpio_out_o  = out_q;
    assign gpio_dir_o  = dir_q;

endmodule

//--- apb_if.sv
// APB interface between the bus decoder and the peripherals, master and slave modports
`timescale 1ns/1ps

interface apb_if;

    // Request side, offset only since the decoder strips the select field
    logic [soc_periph_pkg::REG_OFFSET_WIDTH-1:0] paddr;
    logic [soc_periph_pkg::APB_DATA_WIDTH-1:0]   pwdata;
    logic                                        pwrite;
    logic                                        psel;
    logic                                        penable;

    // Response side
    logic [soc_periph_pkg::APB_DATA_WIDTH-1:0]   prdata;
    logic                                        pready;
    logic                                        pslverr;

    // Decoder end
    modport master (
        output paddr, pwdata, pwrite, psel, penable,
        input  prdata, pready, pslverr
    );

    // Peripheral end
    modport slave (
        input  paddr, pwdata, pwrite, psel, penable,
        output prdata, pready, pslverr
    );

endinterface

//--- apb_timer_unit.sv
// APB compare timer with enable, 32-bit counter, compare register and match event
`timescale 1ns/1ps

module apb_timer_unit (
    input  logic clk_i,
    input  logic rst_n_i,
    apb_if.slave apb,
    output logic timer_event_o
);

    soc_periph_pkg::timer_reg_e                 reg_addr;
    logic                                       wr_en;
    logic                                       cfg_wr;
    logic                                       cnt_wr;
    logic                                       match;
    logic                                       en_q;
    logic [soc_periph_pkg::APB_DATA_WIDTH-1:0]  cnt_q;
    logic [soc_periph_pkg::APB_DATA_WIDTH-1:0]  cmp_q;

    assign reg_addr = soc_periph_pkg::timer_reg_e'(apb.paddr);
    assign wr_en    = apb.psel & apb.penable & apb.pwrite;
    assign cfg_wr   = wr_en & (reg_addr == soc_periph_pkg::TIMER_CFG);
    assign cnt_wr   = wr_en & (reg_addr == soc_periph_pkg::TIMER_CNT);

    // Match only counts while running
    assign match         = en_q & (cnt_q == cmp_q);
    assign timer_event_o = match;

    //////////////////////////////////////////////////////////////////////
    // Configuration and compare
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            en_q  <= 1'b0;
            cmp_q <= '0;
        end else begin
            // Bit 0 is the enable, bit 1 only clears
            if (cfg_wr) begin
                en_q <= apb.pwdata[0];
            end
            if (wr_en && reg_addr == soc_periph_pkg::TIMER_CMP) begin
                cmp_q <= apb.pwdata;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Counter
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cnt_q <= '0;
        end else if (cnt_wr) begin
            // Bus load beats counting
            cnt_q <= apb.pwdata;
        end else if (cfg_wr && apb.pwdata[1]) begin
            cnt_q <= '0;
        end else if (match) begin
            // Wrap so matches are cmp+1 cycles apart
            cnt_q <= '0;
        end else if (en_q) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // Read mux
    always_comb begin
        case (reg_addr)
            soc_periph_pkg::TIMER_CFG: apb.prdata = {{(soc_periph_pkg::APB_DATA_WIDTH-1){1'b0}}, en_q};
            soc_periph_pkg::TIMER_CNT: apb.prdata = cnt_q;
            soc_periph_pkg::TIMER_CMP: apb.prdata = cmp_q;
            default:                   apb.prdata = '0;
        endcase
    end

    // Zero wait states, never an error
    assign apb.pready  = 1'b1;
    assign apb.pslverr = 1'b0;

endmodule

//--- periph_bus_decoder.sv
// Peripheral bus decoder, routes one APB port to the GPIO and timer slaves
`timescale 1ns/1ps

module periph_bus_decoder (
    input  logic [soc_periph_pkg::APB_ADDR_WIDTH-1:0] paddr_i,
    input  logic [soc_periph_pkg::APB_DATA_WIDTH-1:0] pwdata_i,
    input  logic                                      pwrite_i,
    input  logic                                      psel_i,
    input  logic                                      penable_i,
    output logic [soc_periph_pkg::APB_DATA_WIDTH-1:0] prdata_o,
    output logic                                      pready_o,
    output logic                                      pslverr_o,
    apb_if.master                                     gpio_apb,
    apb_if.master                                     timer_apb
);

    logic [soc_periph_pkg::PERIPH_SEL_WIDTH-1:0] sel_field;
    logic                                        gpio_hit;
    logic                                        timer_hit;

    // Select field picks the slave
    assign sel_field = paddr_i[soc_periph_pkg::PERIPH_SEL_LSB +: soc_periph_pkg::PERIPH_SEL_WIDTH];
    assign gpio_hit  = (sel_field == soc_periph_pkg::GPIO_SEL);
    assign timer_hit = (sel_field == soc_periph_pkg::TIMER_SEL);

    //////////////////////////////////////////////////////////////////////
    // Request fan-out
    //////////////////////////////////////////////////////////////////////
    // Shared request lines, only psel is per slave
    assign gpio_apb.paddr    = paddr_i[soc_periph_pkg::REG_OFFSET_WIDTH-1:0];
    assign gpio_apb.pwdata   = pwdata_i;
    assign gpio_apb.pwrite   = pwrite_i;
    assign gpio_apb.penable  = penable_i;
    assign gpio_apb.psel     = psel_i & gpio_hit;

    assign timer_apb.paddr   = paddr_i[soc_periph_pkg::REG_OFFSET_WIDTH-1:0];
    assign timer_apb.pwdata  = pwdata_i;
    assign timer_apb.pwrite  = pwrite_i;
    assign timer_apb.penable = penable_i;
    assign timer_apb.psel    = psel_i & timer_hit;

    //////////////////////////////////////////////////////////////////////
    // Response mux
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        if (gpio_hit) begin
            prdata_o  = gpio_apb.prdata;
            pready_o  = gpio_apb.pready;
            pslverr_o = gpio_apb.pslverr;
        end else if (timer_hit) begin
            prdata_o  = timer_apb.prdata;
            pready_o  = timer_apb.pready;
            pslverr_o = timer_apb.pslverr;
        end else begin
            // Unmapped hole, complete at once with an error
            prdata_o  = '0;
            pready_o  = 1'b1;
            pslverr_o = 1'b1;
        end
    end

endmodule

//--- project.f
soc_periph_pkg.sv
apb_if.sv
periph_bus_decoder.sv
apb_gpio.sv
apb_timer_unit.sv
soc_event_map.sv
soc_peripherals.sv
tb_soc_peripherals_assert.sv
tb_soc_peripherals.sv

//--- soc_event_map.sv
// Reference clock edge detector and FC event vector assembly
`timescale 1ns/1ps

module soc_event_map (
    input  logic                                       clk_i,
    input  logic                                       rst_n_i,
    input  logic                                       slow_clk_i,
    input  logic                                       timer_event_i,
    input  logic                                       gpio_event_i,
    output logic [soc_periph_pkg::FC_EVENTS_WIDTH-1:0] fc_events_o
);

    logic ref_q1;
    logic ref_q2;
    logic ref_hist_q;
    logic ref_event;

    //////////////////////////////////////////////////////////////////////
    // Slow clock into the system domain
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ref_q1     <= 1'b0;
            ref_q2     <= 1'b0;
            ref_hist_q <= 1'b0;
        end else begin
            ref_q1     <= slow_clk_i;
            ref_q2     <= ref_q1;
            ref_hist_q <= ref_q2;
        end
    end

    // Both edges give one pulse
    assign ref_event = ref_q2 ^ ref_hist_q;

    // Fixed bit positions, rest reserved
    always_comb begin
        fc_events_o                                 = '0;
        fc_events_o[soc_periph_pkg::FC_EVT_TIMER]   = timer_event_i;
        fc_events_o[soc_periph_pkg::FC_EVT_REF_CLK] = ref_event;
        fc_events_o[soc_periph_pkg::FC_EVT_GPIO]    = gpio_event_i;
    end

endmodule

//--- soc_periph_pkg.sv
// Bus widths, address map, event bit positions and register offset enums
package soc_periph_pkg;

    //////////////////////////////////////////////////////////////////////
    // Bus and pin widths
    //////////////////////////////////////////////////////////////////////
    localparam int APB_ADDR_WIDTH  = 32;
    localparam int APB_DATA_WIDTH  = 32;
    localparam int NGPIO           = 32;
    localparam int FC_EVENTS_WIDTH = 32;

    //////////////////////////////////////////////////////////////////////
    // Address map, select field is paddr[15:12]
    //////////////////////////////////////////////////////////////////////
    localparam int PERIPH_SEL_LSB   = 12;
    localparam int PERIPH_SEL_WIDTH = 4;
    localparam int REG_OFFSET_WIDTH = 12;

    // Base 0x1000
    localparam logic [PERIPH_SEL_WIDTH-1:0] GPIO_SEL  = 4'd1;
    // Base 0xB000
    localparam logic [PERIPH_SEL_WIDTH-1:0] TIMER_SEL = 4'd11;

    // Positions inside the FC event vector
    localparam int FC_EVT_TIMER   = 10;
    localparam int FC_EVT_REF_CLK = 14;
    localparam int FC_EVT_GPIO    = 15;

    // GPIO register map
    typedef enum logic [REG_OFFSET_WIDTH-1:0] {
        GPIO_PADDIR    = 12'h000,
        GPIO_PADIN     = 12'h004,
        GPIO_PADOUT    = 12'h008,
        GPIO_INTEN     = 12'h00C,
        GPIO_INTSTATUS = 12'h010
    } gpio_reg_e;

    // Timer register map
    typedef enum logic [REG_OFFSET_WIDTH-1:0] {
        TIMER_CFG = 12'h000,
        TIMER_CNT = 12'h004,
        TIMER_CMP = 12'h008
    } timer_reg_e;

endpackage

//--- soc_peripherals.sv
// Peripheral subsystem top level with APB decoder, GPIO, timer and event map
`timescale 1ns/1ps

module soc_peripherals (
    input  logic                                       clk_i,
    input  logic                                       rst_n_i,
    // Incoming APB port
    input  logic [soc_periph_pkg::APB_ADDR_WIDTH-1:0]  apb_paddr_i,
    input  logic [soc_periph_pkg::APB_DATA_WIDTH-1:0]  apb_pwdata_i,
    input  logic                                       apb_pwrite_i,
    input  logic                                       apb_psel_i,
    input  logic                                       apb_penable_i,
    output logic [soc_periph_pkg::APB_DATA_WIDTH-1:0]  apb_prdata_o,
    output logic                                       apb_pready_o,
    output logic                                       apb_pslverr_o,
    // Reference clock
    input  logic                                       slow_clk_i,
    // Pads
    input  logic [soc_periph_pkg::NGPIO-1:0]           gpio_in_i,
    output logic [soc_periph_pkg::NGPIO-1:0]           gpio_out_o,
    output logic [soc_periph_pkg::NGPIO-1:0]           gpio_dir_o,
    // Events to the fabric controller
    output logic [soc_periph_pkg::FC_EVENTS_WIDTH-1:0] fc_events_o
);

    apb_if gpio_bus ();
    apb_if timer_bus ();

    logic gpio_event;
    logic timer_event;

    //////////////////////////////////////////////////////////////////////
    // Bus decode
    //////////////////////////////////////////////////////////////////////
    periph_bus_decoder periph_bus_decoder_i (
        .paddr_i   ( apb_paddr_i   ),
        .pwdata_i  ( apb_pwdata_i  ),
        .pwrite_i  ( apb_pwrite_i  ),
        .psel_i    ( apb_psel_i    ),
        .penable_i ( apb_penable_i ),
        .prdata_o  ( apb_prdata_o  ),
        .pready_o  ( apb_pready_o  ),
        .pslverr_o ( apb_pslverr_o ),
        .gpio_apb  ( gpio_bus      ),
        .timer_apb ( timer_bus     )
    );

    //////////////////////////////////////////////////////////////////////
    // Peripherals
    //////////////////////////////////////////////////////////////////////
    apb_gpio apb_gpio_i (
        .clk_i        ( clk_i      ),
        .rst_n_i      ( rst_n_i    ),
        .apb          ( gpio_bus   ),
        .gpio_in_i    ( gpio_in_i  ),
        .gpio_out_o   ( gpio_out_o ),
        .gpio_dir_o   ( gpio_dir_o ),
        .gpio_event_o ( gpio_event )
    );

    apb_timer_unit apb_timer_unit_i (
        .clk_i         ( clk_i       ),
        .rst_n_i       ( rst_n_i     ),
        .apb           ( timer_bus   ),
        .timer_event_o ( timer_event )
    );

    // Event collection
    soc_event_map soc_event_map_i (
        .clk_i         ( clk_i       ),
        .rst_n_i       ( rst_n_i     ),
        .slow_clk_i    ( slow_clk_i  ),
        .timer_event_i ( timer_event ),
        .gpio_event_i  ( gpio_event  ),
        .fc_events_o   ( fc_events_o )
    );

endmodule

//--- tb_soc_peripherals.sv
// Testbench for the peripheral subsystem with APB tasks, reference model, event monitor and timeout
`timescale 1ns/1ps

module tb_soc_peripherals;

    localparam int          CLK_PERIOD  = 40;
    localparam int          DRIVE_DELAY = 2;
    // Far above the longest run, which stays under 400 cycles
    localparam int          MAX_CYCLES  = 4000;
    localparam logic [31:0] GPIO_BASE   = 32'h0000_1000;
    localparam logic [31:0] TIMER_BASE  = 32'h0000_B000;
    // Select field 5 has no slave
    localparam logic [31:0] HOLE_BASE   = 32'h0000_5000;

    logic        clk_i;
    logic        rst_n_i;
    logic [31:0] paddr;
    logic [31:0] pwdata;
    logic        pwrite;
    logic        psel;
    logic        penable;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        slow_clk;
    logic [31:0] gpio_in;
    logic [31:0] gpio_out;
    logic [31:0] gpio_dir;
    logic [31:0] fc_events;

    // Model registers, 0..4 GPIO by offset/4, 5..7 timer CFG, CNT, CMP
    logic [31:0] model_regs [0:7];
    logic [31:0] rng_state;
    int          cycle_count = 0;
    int          gpio_pulses = 0;
    int          ref_pulses  = 0;
    int          timer_stamps [$];

    soc_peripherals soc_peripherals_i (
        .clk_i         ( clk_i     ),
        .rst_n_i       ( rst_n_i   ),
        .apb_paddr_i   ( paddr     ),
        .apb_pwdata_i  ( pwdata    ),
        .apb_pwrite_i  ( pwrite    ),
        .apb_psel_i    ( psel      ),
        .apb_penable_i ( penable   ),
        .apb_prdata_o  ( prdata    ),
        .apb_pready_o  ( pready    ),
        .apb_pslverr_o ( pslverr   ),
        .slow_clk_i    ( slow_clk  ),
        .gpio_in_i     ( gpio_in   ),
        .gpio_out_o    ( gpio_out  ),
        .gpio_dir_o    ( gpio_dir  ),
        .fc_events_o   ( fc_events )
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD/2) clk_i = ~clk_i;
    end

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////
    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // Slot of a mapped register, -1 for holes and unknown offsets
    function automatic int reg_index(input logic [31:0] addr);
        int idx;
        idx = -1;
        if (addr[15:12] == 4'd1) begin
            case (addr[11:0])
                12'h000: idx = 0;
                12'h004: idx = 1;
                12'h008: idx = 2;
                12'h00C: idx = 3;
                12'h010: idx = 4;
                default: idx = -1;
            endcase
        end else if (addr[15:12] == 4'd11) begin
            case (addr[11:0])
                12'h000: idx = 5;
                12'h004: idx = 6;
                12'h008: idx = 7;
                default: idx = -1;
            endcase
        end
        return idx;
    endfunction

    function automatic logic expect_error(input logic [31:0] addr);
        return !(addr[15:12] == 4'd1 || addr[15:12] == 4'd11);
    endfunction

    function automatic logic [31:0] ref_read(input logic [31:0] addr);
        int idx;
        idx = reg_index(addr);
        if (idx < 0) begin
            return '0;
        end
        return model_regs[idx];
    endfunction

    task automatic model_write(input logic [31:0] addr, input logic [31:0] data);
        int idx;
        idx = reg_index(addr);
        case (idx)
            // Holes, PADIN and INTSTATUS ignore writes
            -1, 1, 4: ;
            5: begin
                // Only the enable is stored, bit 1 clears the count
                model_regs[5] = {31'b0, data[0]};
                if (data[1]) begin
                    model_regs[6] = '0;
                end
            end
            default: model_regs[idx] = data;
        endcase
    endtask

    //////////////////////////////////////////////////////////////////////
    // Checks and bus tasks
    //////////////////////////////////////////////////////////////////////
    task automatic check_value(input string test_name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %s expected %h actual %h", test_name, expected, actual);
            $display("Testbench failed");
            $fatal(1, "mismatch in %s", test_name);
        end
    endtask

    // Lands 2 ns past the next rising edge
    task automatic next_cycle();
        @(posedge clk_i);
        #DRIVE_DELAY;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) next_cycle();
    endtask

    task automatic apb_transfer(input logic write, input logic [31:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic err);
        paddr   = addr;
        pwdata  = wdata;
        pwrite  = write;
        psel    = 1'b1;
        penable = 1'b0;
        next_cycle();
        penable = 1'b1;
        // Zero wait states, so the access phase is one cycle, sampled mid cycle
        @(negedge clk_i);
        check_value("pready in access phase", 1'b1, pready);
        rdata = prdata;
        err   = pslverr;
        next_cycle();
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input string test_name, input logic [31:0] addr,
                             input logic [31:0] data);
        logic [31:0] rdata;
        logic        err;
        apb_transfer(1'b1, addr, data, rdata, err);
        check_value($sformatf("%s pslverr", test_name), expect_error(addr), err);
        model_write(addr, data);
    endtask

    task automatic apb_read(input string test_name, input logic [31:0] addr);
        logic [31:0] rdata;
        logic        err;
        apb_transfer(1'b0, addr, '0, rdata, err);
        check_value(test_name, ref_read(addr), rdata);
        check_value($sformatf("%s pslverr", test_name), expect_error(addr), err);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Event monitor and timeout
    //////////////////////////////////////////////////////////////////////
    // Pulses span a full cycle, so each is seen at exactly one falling edge
    always @(negedge clk_i) begin
        if (rst_n_i) begin
            check_value("reserved event bits", 32'h0, fc_events & ~32'h0000_C400);
            if (fc_events[10]) timer_stamps.push_back(cycle_count);
            if (fc_events[14]) ref_pulses++;
            if (fc_events[15]) gpio_pulses++;
        end
    end

    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Testbench failed");
            $fatal(1, "timeout");
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////
    initial begin
        logic [31:0] val;
        logic [31:0] mask;
        int          cmp;
        int          toggles;
        rng_state = 32'hee97a6d4;
        rst_n_i   = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        pwrite    = 1'b0;
        psel      = 1'b0;
        penable   = 1'b0;
        slow_clk  = 1'b0;
        gpio_in   = '0;
        foreach (model_regs[i]) model_regs[i] = '0;
        repeat (3) @(posedge clk_i);
        #DRIVE_DELAY;
        rst_n_i = 1'b1;

        // GPIO direction, output and input registers
        val = next_rand();
        apb_write("paddir", GPIO_BASE + 32'h0, val);
        check_value("gpio_dir_o", val, gpio_dir);
        val = next_rand();
        apb_write("padout", GPIO_BASE + 32'h8, val);
        check_value("gpio_out_o", val, gpio_out);
        apb_read("paddir readback", GPIO_BASE + 32'h0);
        apb_read("padout readback", GPIO_BASE + 32'h8);
        gpio_in       = next_rand();
        model_regs[1] = gpio_in;
        wait_cycles(4);
        apb_read("padin", GPIO_BASE + 32'h4);

        // GPIO interrupt, pins rise from zero
        gpio_in       = '0;
        model_regs[1] = '0;
        wait_cycles(4);
        mask = next_rand();
        apb_write("inten", GPIO_BASE + 32'hC, mask);
        gpio_pulses   = 0;
        val           = next_rand();
        gpio_in       = val;
        model_regs[1] = val;
        wait_cycles(5);
        model_regs[4] = val & mask;
        apb_read("intstatus", GPIO_BASE + 32'h10);
        check_value("gpio event pulses", ((val & mask) != 0) ? 1 : 0, gpio_pulses);
        model_regs[4] = '0;
        apb_read("intstatus after clear", GPIO_BASE + 32'h10);

        // Timer period, matches are cmp+1 cycles apart
        cmp = 3 + int'(next_rand() % 18);
        apb_write("timer cmp", TIMER_BASE + 32'h8, cmp);
        timer_stamps.delete();
        apb_write("timer clear and enable", TIMER_BASE + 32'h0, 32'h3);
        while (timer_stamps.size() < 4) next_cycle();
        for (int i = 0; i < 3; i++) begin
            check_value("timer interval", cmp + 1, timer_stamps[i+1] - timer_stamps[i]);
        end
        apb_write("timer stop", TIMER_BASE + 32'h0, 32'h0);

        // Timer counter load and clear
        apb_write("timer cnt", TIMER_BASE + 32'h4, next_rand());
        apb_read("timer cnt readback", TIMER_BASE + 32'h4);
        apb_write("timer clear", TIMER_BASE + 32'h0, 32'h2);
        apb_read("timer cnt cleared", TIMER_BASE + 32'h4);
        apb_read("timer cfg", TIMER_BASE + 32'h0);

        // Reference clock, one pulse per edge
        ref_pulses = 0;
        toggles    = 4 + int'(next_rand() % 7);
        repeat (toggles) begin
            slow_clk = ~slow_clk;
            wait_cycles(4 + int'(next_rand() % 3));
        end
        wait_cycles(5);
        check_value("ref clk pulses", toggles, ref_pulses);

        // Decode errors
        apb_read("unmapped read", HOLE_BASE);
        apb_write("unmapped write", HOLE_BASE, next_rand());
        apb_read("paddir after hole", GPIO_BASE + 32'h0);
        apb_read("padout after hole", GPIO_BASE + 32'h8);
        apb_read("unknown gpio offset", GPIO_BASE + 32'h20);

        $display("Testbench passed");
        $finish;
    end

endmodule

//--- tb_soc_peripherals_assert.sv
// Concurrent checks on the incoming APB handshake and the FC event pulse widths
`timescale 1ns/1ps

module tb_soc_peripherals_assert (
    input logic                                       clk_i,
    input logic                                       rst_n_i,
    input logic                                       psel_i,
    input logic                                       penable_i,
    input logic [soc_periph_pkg::APB_ADDR_WIDTH-1:0]  paddr_i,
    input logic [soc_periph_pkg::FC_EVENTS_WIDTH-1:0] fc_events_i
);

    // Event bit may not stay high into the next cycle
    property single_pulse(logic ev);
        @(posedge clk_i) disable iff (!rst_n_i) ev |=> !ev;
    endproperty

    //////////////////////////////////////////////////////////////////////
    // APB protocol
    //////////////////////////////////////////////////////////////////////
    penable_needs_psel: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) penable_i |-> psel_i
    ) else $error("penable high while psel is low");

    // Address held from setup into access
    paddr_stable: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) (psel_i && !penable_i) |=> $stable(paddr_i)
    ) else $error("paddr changed between setup and access");

    //////////////////////////////////////////////////////////////////////
    // Event pulses
    //////////////////////////////////////////////////////////////////////
    timer_pulse: assert property (single_pulse(fc_events_i[soc_periph_pkg::FC_EVT_TIMER]))
        else $error("timer event high for two cycles");
    ref_clk_pulse: assert property (single_pulse(fc_events_i[soc_periph_pkg::FC_EVT_REF_CLK]))
        else $error("reference clock event high for two cycles");
    gpio_pulse: assert property (single_pulse(fc_events_i[soc_periph_pkg::FC_EVT_GPIO]))
        else $error("GPIO event high for two cycles");

endmodule

// Top level sees both the decoder input port and the event vector
bind soc_peripherals tb_soc_peripherals_assert soc_peripherals_assert_i (
    .clk_i       ( clk_i         ),
    .rst_n_i     ( rst_n_i       ),
    .psel_i      ( apb_psel_i    ),
    .penable_i   ( apb_penable_i ),
    .paddr_i     ( apb_paddr_i   ),
    .fc_events_i ( fc_events_o   )
);
